//--- common/radio_pkg.sv
package radio_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   localparam int adc_w      = 14;
   localparam int sample_w   = 16;
   localparam int set_addr_w = 8;
   localparam int set_data_w = 32;
   localparam int time_w     = 24;

   //////////////////////////////////////////////////////////////////////
   // Settings bus register map
   localparam logic [set_addr_w-1:0] sr_rx_ctrl  = 8'd0;
   localparam logic [set_addr_w-1:0] sr_rx_decim = 8'd1;
   localparam logic [set_addr_w-1:0] sr_rx_spp   = 8'd2;
   localparam logic [set_addr_w-1:0] sr_time     = 8'd3;
   localparam logic [set_addr_w-1:0] sr_led_sw   = 8'd4;
   localparam logic [set_addr_w-1:0] sr_led_src  = 8'd5;

   // Limits and reset values
   localparam int         decim_max_log2 = 4;
   localparam logic [7:0] spp_rst        = 8'd16;
   // Run and overrun LEDs start under hardware control
   localparam logic [7:0] led_src_rst    = 8'h03;

   //////////////////////////////////////////////////////////////////////
   // Stream word, read as a packet header or as one I/Q sample
   typedef union packed {
      struct packed {
         logic [7:0]        seq;
         logic [time_w-1:0] vtime;
      } hdr;
      struct packed {
         logic [sample_w-1:0] i;
         logic [sample_w-1:0] q;
      } smp;
   } stream_word_u;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the radio RX testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module radio_tb -o radio_sim \
   && ./obj_dir/radio_sim | tee /dev/stderr | grep -q "Test completed successfully" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- rx/rx_decimator.sv
module rx_decimator (
   input  logic                           dsp_clk,
   input  logic                           por_rst,
   input  logic [2:0]                     decim_log2_i,
   input  logic                           valid_i,
   input  logic [radio_pkg::sample_w-1:0] sample_i_i,
   input  logic [radio_pkg::sample_w-1:0] sample_q_i,
   output logic                           valid_o,
   output logic [radio_pkg::sample_w-1:0] sample_i_o,
   output logic [radio_pkg::sample_w-1:0] sample_q_o
);
   import radio_pkg::*;

   // Headroom for 2^decim_max_log2 full scale samples
   localparam int acc_w = sample_w + decim_max_log2;
   localparam int cnt_w = decim_max_log2;

   logic [2:0]              k_q;
   logic [cnt_w-1:0]        cnt;
   logic [cnt_w-1:0]        cnt_base;
   logic [cnt_w-1:0]        grp_mask;
   logic                    last;
   logic signed [acc_w-1:0] acc_i;
   logic signed [acc_w-1:0] acc_q;
   logic signed [acc_w-1:0] sum_i;
   logic signed [acc_w-1:0] sum_q;

   // New k starts a fresh group with this input
   assign cnt_base = (decim_log2_i != k_q) ? '0 : cnt;
   assign grp_mask = cnt_w'((1 << decim_log2_i) - 1);
   assign last     = (cnt_base == grp_mask);

   // First input of a group replaces the old sum
   assign sum_i = ((cnt_base == '0) ? '0 : acc_i) + acc_w'($signed(sample_i_i));
   assign sum_q = ((cnt_base == '0) ? '0 : acc_q) + acc_w'($signed(sample_q_i));

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         k_q     <= '0;
         cnt     <= '0;
         valid_o <= 1'b0;
      end else begin
         k_q     <= decim_log2_i;
         valid_o <= valid_i && last;
         if (!valid_i || last) begin
            cnt <= '0;
         end else begin
            cnt <= cnt_base + 1'b1;
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (valid_i) begin
         acc_i <= sum_i;
         acc_q <= sum_q;
      end
      if (valid_i && last) begin
         sample_i_o <= sample_w'(sum_i >>> decim_log2_i);
         sample_q_o <= sample_w'(sum_q >>> decim_log2_i);
      end
   end

   k_in_range: assert property (@(posedge dsp_clk) disable iff (por_rst)
      decim_log2_i <= 3'(decim_max_log2));

endmodule

//--- rx/rx_framer.sv
module rx_framer #(
   parameter int fifo_depth = 4
) (
   input  logic                           dsp_clk,
   input  logic                           por_rst,
   input  logic                           run_i,
   input  logic [7:0]                     spp_i,
   input  logic [radio_pkg::time_w-1:0]   vita_time_i,
   input  logic                           valid_i,
   input  logic [radio_pkg::sample_w-1:0] sample_i_i,
   input  logic [radio_pkg::sample_w-1:0] sample_q_i,
   output logic                           stream_req_o,
   output logic [31:0]                    stream_data_o,
   input  logic                           stream_ack_i,
   output logic                           overrun_o
);
   import radio_pkg::*;

   localparam int aw    = $clog2(fifo_depth);
   localparam int ptr_w = aw + 1;

   stream_word_u     mem [fifo_depth];
   stream_word_u     hdr_word;
   stream_word_u     smp_word;
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] wr_ptr_p1;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w-1:0] used;
   logic [7:0]       smp_cnt;
   logic [7:0]       seq;
   logic             dropping;
   logic             accept;
   logic             first;
   logic             live;
   logic             room;
   logic             push;
   logic             pop;
   logic             raise;

   //////////////////////////////////////////////////////////////////////
   // Packet building
   assign accept    = valid_i && run_i;
   assign first     = (smp_cnt == 8'd0);
   assign used      = wr_ptr - rd_ptr;
   assign wr_ptr_p1 = wr_ptr + 1'b1;

   // Header and first sample go in together and need two slots
   assign room = first ? (used <= ptr_w'(fifo_depth - 2)) : (used <= ptr_w'(fifo_depth - 1));
   // Rest of a dropped packet is skipped until the next header
   assign live = accept && (first || !dropping);
   assign push = live && room;

   always_comb begin
      hdr_word.hdr.seq   = seq;
      hdr_word.hdr.vtime = vita_time_i;
      smp_word.smp.i     = sample_i_i;
      smp_word.smp.q     = sample_q_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (push && first) begin
         mem[wr_ptr[aw-1:0]]    <= hdr_word;
         mem[wr_ptr_p1[aw-1:0]] <= smp_word;
      end else if (push) begin
         mem[wr_ptr[aw-1:0]] <= smp_word;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr    <= '0;
         smp_cnt   <= '0;
         seq       <= '0;
         dropping  <= 1'b0;
         overrun_o <= 1'b0;
      end else if (!run_i) begin
         // Stop flushes the queue but keeps the word on the bus
         wr_ptr    <= rd_ptr + ptr_w'(stream_req_o || raise);
         smp_cnt   <= '0;
         seq       <= '0;
         dropping  <= 1'b0;
         overrun_o <= 1'b0;
      end else if (accept) begin
         if (push) begin
            wr_ptr <= first ? wr_ptr + ptr_w'(2) : wr_ptr_p1;
         end
         if (push && first) begin
            seq <= seq + 1'b1;
         end
         if (live) begin
            dropping  <= !room;
            overrun_o <= overrun_o || !room;
         end
         smp_cnt <= (smp_cnt >= spp_i - 8'd1) ? 8'd0 : smp_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Four-phase output
   assign pop   = stream_req_o && stream_ack_i;
   assign raise = !stream_req_o && !stream_ack_i && (used != '0);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rd_ptr       <= '0;
         stream_req_o <= 1'b0;
      end else if (pop) begin
         rd_ptr       <= rd_ptr + 1'b1;
         stream_req_o <= 1'b0;
      end else if (raise) begin
         stream_req_o <= 1'b1;
      end
   end

   assign stream_data_o = mem[rd_ptr[aw-1:0]];

   data_held: assert property (@(posedge dsp_clk) disable iff (por_rst)
      stream_req_o && !stream_ack_i |=> stream_req_o && $stable(stream_data_o));

endmodule

//--- rx/rx_frontend.sv
module rx_frontend (
   input  logic                           dsp_clk,
   input  logic                           por_rst,
   input  logic                           run_i,
   input  logic                           iq_swap_i,
   input  logic [radio_pkg::adc_w-1:0]    adc_a_i,
   input  logic [radio_pkg::adc_w-1:0]    adc_b_i,
   output logic [radio_pkg::sample_w-1:0] sample_i_o,
   output logic [radio_pkg::sample_w-1:0] sample_q_o,
   output logic                           valid_o
);
   import radio_pkg::*;

   localparam int pad_w = sample_w - adc_w;

   logic [sample_w-1:0] pad_a;
   logic [sample_w-1:0] pad_b;

   // ADC words sit in the top bits of the sample
   assign pad_a = {adc_a_i, {pad_w{1'b0}}};
   assign pad_b = {adc_b_i, {pad_w{1'b0}}};

   always_ff @(posedge dsp_clk) begin
      sample_i_o <= iq_swap_i ? pad_b : pad_a;
      sample_q_o <= iq_swap_i ? pad_a : pad_b;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= run_i;
      end
   end

endmodule

//--- src.f
common/radio_pkg.sv
src/radio_settings.sv
src/vita_time.sv
rx/rx_frontend.sv
rx/rx_decimator.sv
rx/rx_framer.sv
src/radio_core.sv
tb/radio_checker.sv
tb/radio_tb.sv

//--- src/radio_core.sv
module radio_core #(
   parameter int fifo_depth = 4
) (
   input  logic                             dsp_clk,
   input  logic                             por_rst,
   input  logic                             set_req_i,
   input  logic [radio_pkg::set_addr_w-1:0] set_addr_i,
   input  logic [radio_pkg::set_data_w-1:0] set_data_i,
   output logic                             set_ack_o,
   input  logic [radio_pkg::adc_w-1:0]      adc_a_i,
   input  logic [radio_pkg::adc_w-1:0]      adc_b_i,
   output logic                             stream_req_o,
   output logic [31:0]                      stream_data_o,
   input  logic                             stream_ack_i,
   output logic                             overrun_o,
   output logic [7:0]                       leds_o
);
   import radio_pkg::*;

   logic                run;
   logic                iq_swap;
   logic [2:0]          decim_log2;
   logic [7:0]          spp;
   logic                time_load;
   logic [time_w-1:0]   time_value;
   logic [time_w-1:0]   vita_now;
   logic                fe_valid;
   logic [sample_w-1:0] fe_i;
   logic [sample_w-1:0] fe_q;
   logic                dec_valid;
   logic [sample_w-1:0] dec_i;
   logic [sample_w-1:0] dec_q;

   //////////////////////////////////////////////////////////////////////
   // Control side
   radio_settings settings0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_req_i(set_req_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .set_ack_o(set_ack_o), .overrun_i(overrun_o),
      .run_o(run), .iq_swap_o(iq_swap), .decim_log2_o(decim_log2), .spp_o(spp),
      .time_load_o(time_load), .time_value_o(time_value), .leds_o(leds_o)
   );

   vita_time time0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .time_load_i(time_load), .time_value_i(time_value), .vita_time_o(vita_now)
   );

   //////////////////////////////////////////////////////////////////////
   // RX pipeline
   rx_frontend frontend0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .run_i(run), .iq_swap_i(iq_swap),
      .adc_a_i(adc_a_i), .adc_b_i(adc_b_i),
      .sample_i_o(fe_i), .sample_q_o(fe_q), .valid_o(fe_valid)
   );

   rx_decimator decim0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .decim_log2_i(decim_log2),
      .valid_i(fe_valid), .sample_i_i(fe_i), .sample_q_i(fe_q),
      .valid_o(dec_valid), .sample_i_o(dec_i), .sample_q_o(dec_q)
   );

   rx_framer #(
      .fifo_depth(fifo_depth)
   ) framer0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .run_i(run), .spp_i(spp),
      .vita_time_i(vita_now),
      .valid_i(dec_valid), .sample_i_i(dec_i), .sample_q_i(dec_q),
      .stream_req_o(stream_req_o), .stream_data_o(stream_data_o),
      .stream_ack_i(stream_ack_i), .overrun_o(overrun_o)
   );

endmodule

//--- src/radio_settings.sv
module radio_settings (
   input  logic                             dsp_clk,
   input  logic                             por_rst,
   input  logic                             set_req_i,
   input  logic [radio_pkg::set_addr_w-1:0] set_addr_i,
   input  logic [radio_pkg::set_data_w-1:0] set_data_i,
   output logic                             set_ack_o,
   input  logic                             overrun_i,
   output logic                             run_o,
   output logic                             iq_swap_o,
   output logic [2:0]                       decim_log2_o,
   output logic [7:0]                       spp_o,
   output logic                             time_load_o,
   output logic [radio_pkg::time_w-1:0]     time_value_o,
   output logic [7:0]                       leds_o
);
   import radio_pkg::*;

   logic       wr_stb;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   // One write per request, taken before the ack goes up
   assign wr_stb = set_req_i && !set_ack_o;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_ack_o <= 1'b0;
      end else if (wr_stb) begin
         set_ack_o <= 1'b1;
      end else if (!set_req_i) begin
         set_ack_o <= 1'b0;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         run_o        <= 1'b0;
         iq_swap_o    <= 1'b0;
         decim_log2_o <= '0;
         spp_o        <= spp_rst;
         led_sw       <= '0;
         led_src      <= led_src_rst;
      end else if (wr_stb) begin
         case (set_addr_i)
            sr_rx_ctrl: begin
               run_o     <= set_data_i[0];
               iq_swap_o <= set_data_i[1];
            end
            sr_rx_decim: begin
               if (set_data_i > set_data_w'(decim_max_log2)) begin
                  decim_log2_o <= 3'(decim_max_log2);
               end else begin
                  decim_log2_o <= set_data_i[2:0];
               end
            end
            // Zero samples per packet makes no sense, treat as one
            sr_rx_spp:  spp_o   <= (set_data_i[7:0] == 8'd0) ? 8'd1 : set_data_i[7:0];
            sr_led_sw:  led_sw  <= set_data_i[7:0];
            sr_led_src: led_src <= set_data_i[7:0];
            default: ;
         endcase
      end
   end

   // Time load lands on the same edge as the write
   assign time_load_o  = wr_stb && (set_addr_i == sr_time);
   assign time_value_o = set_data_i[time_w-1:0];

   //////////////////////////////////////////////////////////////////////
   // LED mux, source bit 1 selects hardware
   assign led_hw = {6'b0, overrun_i, run_o};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   ack_needs_req: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $rose(set_ack_o) |-> set_req_i);

endmodule

//--- src/vita_time.sv
module vita_time (
   input  logic                         dsp_clk,
   input  logic                         por_rst,
   input  logic                         time_load_i,
   input  logic [radio_pkg::time_w-1:0] time_value_i,
   output logic [radio_pkg::time_w-1:0] vita_time_o
);

   // Sample clock tick counter, narrowed to the header time field
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o <= '0;
      end else if (time_load_i) begin
         vita_time_o <= time_value_i;
      end else begin
         // wraps silently at 2^24
         vita_time_o <= vita_time_o + 1'b1;
      end
   end

endmodule

//--- tb/radio_checker.sv
module radio_checker (
   input  logic                         dsp_clk,
   input  logic                         por_rst,
   input  logic [2:0]                   mode_i,
   input  logic                         swap_i,
   input  logic [2:0]                   k_i,
   input  logic [7:0]                   spp_i,
   input  logic [radio_pkg::time_w-1:0] tload_i,
   input  logic [radio_pkg::adc_w-1:0]  adc_a_i,
   input  logic [radio_pkg::adc_w-1:0]  adc_b_i,
   input  logic                         stream_req_i,
   input  logic [31:0]                  stream_data_i,
   output logic                         stream_ack_o,
   input  logic                         overrun_i,
   input  logic [7:0]                   leds_i
);
   import radio_pkg::*;

   localparam logic [2:0] m_quiet = 3'd1;
   localparam logic [2:0] m_const = 3'd2;
   localparam logic [2:0] m_ramp  = 3'd3;
   localparam logic [2:0] m_frame = 3'd4;
   localparam logic [2:0] m_tload = 3'd5;
   localparam logic [2:0] m_hold  = 3'd6;

   integer            seed = 47328;
   int                delay;
   int                err_cnt = 0;
   int                check_cnt = 0;
   int                test_cnt = 0;
   int                test_bad = 0;
   int                err_at_start;
   int                smp_seen;
   int                hdr_seen;
   int                smp_left;
   string             cur_test;
   logic [2:0]        mode_q = 3'd0;
   logic [7:0]        exp_seq;
   logic              have_prev;
   logic              have_hdr;
   logic              ovr_seen;
   stream_word_u      prev_w;
   logic [time_w-1:0] prev_time;

   // Expected sample word: pad, optional swap, then average over 2^k equal inputs
   function automatic stream_word_u ref_sample(input logic [adc_w-1:0] a,
                                               input logic [adc_w-1:0] b,
                                               input logic swap, input logic [2:0] k);
      logic signed [sample_w+decim_max_log2-1:0] sum_i;
      logic signed [sample_w+decim_max_log2-1:0] sum_q;
      logic [sample_w-1:0] pi;
      logic [sample_w-1:0] pq;
      stream_word_u        r;
      int                  n;
      pi = swap ? {b, {(sample_w-adc_w){1'b0}}} : {a, {(sample_w-adc_w){1'b0}}};
      pq = swap ? {a, {(sample_w-adc_w){1'b0}}} : {b, {(sample_w-adc_w){1'b0}}};
      sum_i = '0;
      sum_q = '0;
      for (n = 0; n < (1 << k); n++) begin
         sum_i = sum_i + $signed(pi);
         sum_q = sum_q + $signed(pq);
      end
      r.smp.i = sample_w'(sum_i >>> k);
      r.smp.q = sample_w'(sum_q >>> k);
      return r;
   endfunction

   task automatic fail_msg(input string msg);
      $display("error at %0t: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         $display("error at %0t: %s got %h expected %h", $time, sig, got, exp);
         err_cnt++;
      end
   endtask

   // LED mux rule, hardware bits are run and overrun
   task automatic check_leds(input logic [7:0] src, input logic [7:0] sw,
                             input logic run, input logic ovr);
      logic [7:0] hw;
      logic [7:0] want;
      int         b;
      hw    = 8'h00;
      hw[0] = run;
      hw[1] = ovr;
      for (b = 0; b < 8; b++) begin
         want[b] = src[b] ? hw[b] : sw[b];
      end
      check_val("leds_o", 32'(leds_i), 32'(want));
   endtask

   task automatic begin_test(input string name);
      cur_test     = name;
      err_at_start = err_cnt;
      smp_seen     = 0;
      hdr_seen     = 0;
   endtask

   task automatic end_test(input bit need_words);
      if (need_words && (smp_seen == 0 || hdr_seen == 0)) begin
         fail_msg("no packets arrived on the stream output");
      end
      test_cnt++;
      if (err_cnt != err_at_start) begin
         test_bad++;
         $display("test %s: %0d errors", cur_test, err_cnt - err_at_start);
      end else begin
         $display("test %s: ok (%0d headers, %0d samples)", cur_test, hdr_seen, smp_seen);
      end
   endtask

   task automatic report_totals();
      $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
               test_cnt, test_bad, check_cnt, err_cnt);
   endtask

   task automatic take_word(input stream_word_u w);
      logic [time_w-1:0] diff;
      logic [time_w-1:0] step;
      step = time_w'(spp_i) << k_i;
      // Samples carry the ADC sign bit, headers a small sequence number
      if (w[31]) begin
         smp_seen++;
         // A packet never holds more than spp samples
         if (smp_left == 0) begin
            fail_msg("sample word arrived where a header was due");
         end else begin
            smp_left--;
         end
         if (mode_q == m_ramp) begin
            if (have_prev) begin
               check_val("stream_data_o.i step", 32'(sample_w'(w.smp.i - prev_w.smp.i)), 4);
               check_val("stream_data_o.q step", 32'(sample_w'(w.smp.q - prev_w.smp.q)), 4);
            end
            prev_w    = w;
            have_prev = 1'b1;
         end else begin
            check_val("stream_data_o", w, ref_sample(adc_a_i, adc_b_i, swap_i, k_i));
         end
      end else begin
         hdr_seen++;
         have_prev = 1'b0;
         // Short packets only come from a drop
         if (have_hdr && smp_left != 0 && !ovr_seen) begin
            fail_msg("header arrived before the packet had spp samples");
         end
         smp_left = spp_i;
         check_val("stream_data_o.seq", 32'(w.hdr.seq), 32'(exp_seq));
         exp_seq = w.hdr.seq + 8'd1;
         if (mode_q == m_frame && have_hdr) begin
            diff = w.hdr.vtime - prev_time;
            if (!ovr_seen) begin
               check_val("header time step", 32'(diff), 32'(step));
            end else if (diff == '0 || (diff % step) != '0) begin
               fail_msg("header time step is not a whole number of packets");
            end
         end
         if (mode_q == m_tload && !have_hdr) begin
            diff = w.hdr.vtime - tload_i;
            check_cnt++;
            if (diff >= 64) begin
               $display("error at %0t: stream_data_o.vtime got %h expected %h to %h",
                        $time, w.hdr.vtime, tload_i, tload_i + 63);
               err_cnt++;
            end
         end
         prev_time = w.hdr.vtime;
         have_hdr  = 1'b1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Stream compare
   always @(posedge dsp_clk) begin
      if (mode_i != mode_q) begin
         exp_seq   = 8'd0;
         have_prev = 1'b0;
         have_hdr  = 1'b0;
         ovr_seen  = 1'b0;
         smp_left  = 0;
         mode_q    = mode_i;
      end
      if (overrun_i) begin
         ovr_seen = 1'b1;
      end
      if (!por_rst && mode_q == m_quiet && stream_req_i) begin
         fail_msg("stream request raised while RX is stopped");
      end
      if (!por_rst && stream_req_i && stream_ack_o && mode_q >= m_const && mode_q <= m_tload) begin
         take_word(stream_data_i);
      end
   end

   // Four-phase responder with a random ack delay
   initial stream_ack_o = 1'b0;

   always begin
      @(posedge dsp_clk);
      if (stream_req_i && mode_i != m_hold) begin
         delay = int'($unsigned($random(seed)) % 3);
         repeat (delay) @(posedge dsp_clk);
         #2 stream_ack_o = 1'b1;
         do @(posedge dsp_clk); while (stream_req_i);
         #2 stream_ack_o = 1'b0;
      end
   end

endmodule

//--- tb/radio_tb.sv
module radio_tb;
   import radio_pkg::*;

   localparam int clk_period = 40;
   localparam logic [2:0] m_idle  = 3'd0;
   localparam logic [2:0] m_quiet = 3'd1;
   localparam logic [2:0] m_const = 3'd2;
   localparam logic [2:0] m_ramp  = 3'd3;
   localparam logic [2:0] m_frame = 3'd4;
   localparam logic [2:0] m_tload = 3'd5;
   localparam logic [2:0] m_hold  = 3'd6;

   // Test lengths in cycles, the watchdog budget follows from them
   localparam int leds_run  = 100;
   localparam int const_run = 200;
   localparam int ramp_run  = 150;
   localparam int frame_run = 400;
   localparam int tload_run = 200;
   localparam int hold_run  = 200;
   localparam int setup_run = 60;
   localparam int watchdog_cycles = 4 + leds_run + 3 * const_run + ramp_run + frame_run
                                    + tload_run + 2 * hold_run + 7 * setup_run + 500;

   logic              dsp_clk = 1'b0;
   logic              por_rst;
   logic              set_req;
   logic [7:0]        set_addr;
   logic [31:0]       set_data;
   logic              set_ack;
   logic [adc_w-1:0]  adc_a;
   logic [adc_w-1:0]  adc_b;
   logic              stream_req;
   logic [31:0]       stream_data;
   logic              stream_ack;
   logic              overrun;
   logic [7:0]        leds;
   logic              ramp_en;
   logic [2:0]        mode_sel;
   logic              swap_cfg;
   logic [2:0]        k_cfg;
   logic [7:0]        spp_cfg;
   logic [time_w-1:0] tload_cfg;
   int                n;

   always #(clk_period / 2) dsp_clk = ~dsp_clk;

   radio_core #(
      .fifo_depth(8)
   ) dut0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_req_i(set_req), .set_addr_i(set_addr), .set_data_i(set_data), .set_ack_o(set_ack),
      .adc_a_i(adc_a), .adc_b_i(adc_b),
      .stream_req_o(stream_req), .stream_data_o(stream_data), .stream_ack_i(stream_ack),
      .overrun_o(overrun), .leds_o(leds)
   );

   radio_checker chk0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .mode_i(mode_sel), .swap_i(swap_cfg),
      .k_i(k_cfg), .spp_i(spp_cfg), .tload_i(tload_cfg), .adc_a_i(adc_a), .adc_b_i(adc_b),
      .stream_req_i(stream_req), .stream_data_i(stream_data), .stream_ack_o(stream_ack),
      .overrun_i(overrun), .leds_i(leds)
   );

   always @(posedge dsp_clk) begin
      #2;
      if (ramp_en) begin
         adc_a = adc_a + 1'b1;
         adc_b = adc_b + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Settings bus and run control
   task automatic set_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge dsp_clk);
      #2;
      set_addr = addr;
      set_data = data;
      set_req  = 1'b1;
      do @(posedge dsp_clk); while (!set_ack);
      #2 set_req = 1'b0;
      do @(posedge dsp_clk); while (set_ack);
   endtask

   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 4) begin
         @(posedge dsp_clk);
         quiet = stream_req ? 0 : quiet + 1;
      end
   endtask

   task automatic start_run(input logic [2:0] m, input logic swap, input logic [2:0] k,
                            input logic [7:0] spp, input bit load, input logic [time_w-1:0] t);
      #2 mode_sel = m_idle;
      set_write(sr_rx_ctrl, 32'd0);
      wait_idle();
      set_write(sr_rx_decim, 32'(k));
      set_write(sr_rx_spp, 32'(spp));
      #2;
      swap_cfg = swap;
      k_cfg    = k;
      spp_cfg  = spp;
      if (load) begin
         tload_cfg = t;
         set_write(sr_time, 32'(t));
      end
      #2 mode_sel = m;
      set_write(sr_rx_ctrl, {30'd0, swap, 1'b1});
   endtask

   initial begin
      #(watchdog_cycles * clk_period);
      $display("watchdog: simulation ran past its time budget");
      $display("Test failed");
      $finish;
   end

   initial begin
      por_rst = 1'b1;
      set_req = 1'b0;
      set_addr = '0;
      set_data = '0;
      adc_a = 14'h2A5C;
      adc_b = 14'h3137;
      ramp_en = 1'b0;
      mode_sel = m_idle;
      swap_cfg = 1'b0;
      k_cfg = 3'd0;
      spp_cfg = 8'd16;
      tload_cfg = '0;
      repeat (4) @(posedge dsp_clk);
      #2 por_rst = 1'b0;

      chk0.begin_test("reset_and_leds");
      mode_sel = m_quiet;
      #2 chk0.check_leds(8'h03, 8'h00, 1'b0, 1'b0);
      set_write(sr_led_sw, 32'hA5);
      #2 chk0.check_leds(8'h03, 8'hA5, 1'b0, 1'b0);
      set_write(sr_led_src, 32'h0F);
      #2 chk0.check_leds(8'h0F, 8'hA5, 1'b0, 1'b0);
      set_write(sr_led_src, 32'h03);
      set_write(sr_led_sw, 32'h00);
      repeat (leds_run) @(posedge dsp_clk);
      chk0.end_test(1'b0);

      chk0.begin_test("constant_input");
      start_run(m_const, 1'b0, 3'd0, 8'd8, 1'b0, '0);
      repeat (const_run) @(posedge dsp_clk);
      start_run(m_const, 1'b0, 3'd3, 8'd8, 1'b0, '0);
      repeat (const_run) @(posedge dsp_clk);
      start_run(m_const, 1'b1, 3'd3, 8'd8, 1'b0, '0);
      repeat (const_run) @(posedge dsp_clk);
      chk0.end_test(1'b1);

      chk0.begin_test("ramp_input");
      #2;
      adc_a = 14'h2000;
      adc_b = 14'h2800;
      ramp_en = 1'b1;
      start_run(m_ramp, 1'b0, 3'd0, 8'd8, 1'b0, '0);
      repeat (ramp_run) @(posedge dsp_clk);
      #2 mode_sel = m_idle;
      ramp_en = 1'b0;
      @(posedge dsp_clk);
      #2;
      adc_a = 14'h2A5C;
      adc_b = 14'h3137;
      chk0.end_test(1'b1);

      chk0.begin_test("framing");
      start_run(m_frame, 1'b0, 3'd2, 8'd5, 1'b0, '0);
      repeat (frame_run) @(posedge dsp_clk);
      chk0.end_test(1'b1);

      chk0.begin_test("time_load");
      start_run(m_tload, 1'b0, 3'd2, 8'd5, 1'b1, 24'h5A5A00);
      repeat (tload_run) @(posedge dsp_clk);
      chk0.end_test(1'b1);

      chk0.begin_test("back_pressure");
      start_run(m_hold, 1'b0, 3'd0, 8'd8, 1'b0, '0);
      n = 0;
      while (!overrun && n < hold_run) begin
         @(posedge dsp_clk);
         n++;
      end
      #2 chk0.check_val("overrun_o", 32'(overrun), 32'd1);
      chk0.check_leds(8'h03, 8'h00, 1'b1, 1'b1);
      set_write(sr_rx_ctrl, 32'd0);
      #2 chk0.check_val("overrun_o", 32'(overrun), 32'd0);
      chk0.check_leds(8'h03, 8'h00, 1'b0, 1'b0);
      // Fresh run has to start again at sequence 0
      start_run(m_frame, 1'b0, 3'd2, 8'd5, 1'b0, '0);
      repeat (hold_run) @(posedge dsp_clk);
      chk0.end_test(1'b1);

      #2 mode_sel = m_idle;
      chk0.report_totals();
      if (chk0.err_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
